//--- list.f
+incdir+.
itim_pkg.sv
itim_array.sv
itim_ctrl.sv
itim.sv
tb_imem_model.sv
tb_itim.sv

//--- run_sim.sh
#!/bin/sh
# build the ITIM testbench with Verilator, run it, and decide from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_itim -f list.f -o sim_itim \
  && ./obj_dir/sim_itim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -qx "all tests passed" sim.log && exit 0 || exit 1

//--- tb_itim.sv
`timescale 1ns/1ps
`default_nettype none
`include "itim_defs.svh"

module tb_itim
  import itim_pkg::*;
();

  localparam logic [31:0] data_key      = 32'h5a5a_a5a5;
  localparam int          line_words    = 2**`ITIM_WIDTH;
  localparam logic [31:0] tag_step      = 32'h1 << (`ITIM_DEPTH + `ITIM_WIDTH + 2);
  localparam int          ready_timeout = 64;
  localparam int          random_runs   = 200;

  logic        clock;
  logic        reset;
  mem_in_type  itim_in;
  mem_out_type itim_out;
  mem_out_type imem_out;
  mem_in_type  imem_in;
  int          fetch_count;

  int errors;
  int test_errors;
  int tests_run;
  int tests_ok;
  int ready_count;
  int valid_cycles;
  bit aborted;

  itim #(
    .itim_enable (1)
  ) DUT (
    .clock    (clock),
    .reset    (reset),
    .itim_in  (itim_in),
    .itim_out (itim_out),
    .imem_out (imem_out),
    .imem_in  (imem_in)
  );

  tb_imem_model #(
    .data_key (data_key),
    .max_wait (4)
  ) mem_model (
    .clock       (clock),
    .reset       (reset),
    .imem_in     (imem_in),
    .imem_out    (imem_out),
    .fetch_count (fetch_count)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // ready pulses toward the processor and busy cycles toward backing memory
  always @(posedge clock) begin
    if (reset) begin
      ready_count <= 0;
      valid_cycles <= 0;
    end else begin
      if (itim_out.mem_ready) ready_count <= ready_count + 1;
      if (imem_in.mem_valid) valid_cycles <= valid_cycles + 1;
    end
  end

  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    return addr ^ data_key;
  endfunction

  task automatic check_equal(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("[ERROR] %0t %s expected %h got %h", $time, name, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  // backing memory only ever sees plain instruction reads
  always @(posedge clock) begin
    if (!reset && imem_in.mem_valid) begin
      check_equal("imem_in.mem_instr", 32'h1, imem_in.mem_instr);
      check_equal("imem_in.mem_fence", 32'h0, imem_in.mem_fence);
      check_equal("imem_in.mem_wstrb", 32'h0, imem_in.mem_wstrb);
      check_equal("imem_in.mem_wdata", 32'h0, imem_in.mem_wdata);
    end
  end

  task automatic wait_ready(output logic [31:0] rdata, output int cycles);
    cycles = 0;
    rdata = '0;
    while (!aborted) begin
      @(posedge clock);
      cycles++;
      if (itim_out.mem_ready) begin
        rdata = itim_out.mem_rdata;
        break;
      end
      assert (cycles < ready_timeout) else begin
        $display("timeout: the ITIM gave no ready within %0d cycles (at %0t)",
                 ready_timeout, $time);
        errors++;
        test_errors++;
        aborted = 1'b1;
      end
    end
  endtask

  // one-cycle request pulse then the answer against the memory rule
  task automatic fetch_and_compare(input logic [31:0] addr, output int cycles);
    logic [31:0] rdata;
    cycles = 0;
    if (!aborted) begin
      itim_in.mem_valid <= 1'b1;
      itim_in.mem_fence <= 1'b0;
      itim_in.mem_instr <= 1'b1;
      itim_in.mem_addr <= addr;
      @(posedge clock);
      itim_in.mem_valid <= 1'b0;
      wait_ready(rdata, cycles);
      if (!aborted) check_equal("itim_out.mem_rdata", expected_word(addr), rdata);
    end
  endtask

  task automatic fence_lines(output logic [31:0] rdata);
    int cycles;
    rdata = '0;
    if (!aborted) begin
      itim_in.mem_valid <= 1'b1;
      itim_in.mem_fence <= 1'b1;
      itim_in.mem_addr <= '0;
      @(posedge clock);
      itim_in.mem_valid <= 1'b0;
      itim_in.mem_fence <= 1'b0;
      wait_ready(rdata, cycles);
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (aborted && test_errors == 0) begin
      $display("%s: skipped after a timeout", name);
    end else if (test_errors == 0) begin
      tests_ok++;
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d error(s)", name, test_errors);
    end
    test_errors = 0;
  endtask

  initial begin : main
    logic [31:0] line_base;
    logic [31:0] addr;
    logic [31:0] rdata;
    int          cycles;
    int          fetch_start;
    int          valid_start;
    int          ready_start;

    void'($urandom(32'hfd45_d3e0));
    errors = 0;
    test_errors = 0;
    tests_run = 0;
    tests_ok = 0;
    aborted = 1'b0;
    reset = 1'b1;
    itim_in = '0;
    line_base = 32'h0000_0120; // line index 2
    repeat (4) @(posedge clock);
    reset <= 1'b0;

    fetch_start = fetch_count;
    fetch_and_compare(line_base + 32'h4, cycles);
    check_equal("fetch_count", fetch_start + line_words, fetch_count);
    for (int i = 0; i < line_words; i++) begin
      check_equal("imem_in.mem_addr", line_base + 32'(4*i),
                  mem_model.addr_log[6'(fetch_start + i)]);
    end
    report_test("miss_fill");

    fetch_start = fetch_count;
    valid_start = valid_cycles;
    for (int i = 0; i < line_words; i++) begin
      fetch_and_compare(line_base + 32'(4*i), cycles);
      check_equal("itim_out.mem_ready latency", 1, cycles);
    end
    check_equal("fetch_count", fetch_start, fetch_count);
    check_equal("imem_in.mem_valid cycles", valid_start, valid_cycles);
    report_test("hit");

    addr = `ITIM_TOP_ADDR + 32'h48;
    for (int n = 0; n < 2; n++) begin
      fetch_start = fetch_count;
      fetch_and_compare(addr, cycles);
      check_equal("fetch_count", fetch_start + 1, fetch_count);
    end
    report_test("outside_window");

    fetch_start = fetch_count;
    fetch_and_compare(line_base + tag_step + 32'h8, cycles); // same index under another tag
    check_equal("fetch_count", fetch_start + 1, fetch_count);
    fetch_start = fetch_count;
    fetch_and_compare(line_base + 32'h8, cycles);
    check_equal("itim_out.mem_ready latency", 1, cycles);
    check_equal("fetch_count", fetch_start, fetch_count);
    report_test("tag_conflict");

    fence_lines(rdata);
    if (!aborted) check_equal("itim_out.mem_rdata", 32'h0, rdata);
    fetch_start = fetch_count;
    fetch_and_compare(line_base + 32'hc, cycles);
    check_equal("fetch_count", fetch_start + line_words, fetch_count);
    report_test("fence");

    repeat (2) @(posedge clock); // counters settle before the snapshot
    ready_start = ready_count;
    for (int n = 0; n < random_runs; n++) begin
      if ($urandom % 2 == 0) begin
        addr = `ITIM_BASE_ADDR + ($urandom % 32'h400); // few tags so plenty of hits
      end else begin
        addr = `ITIM_TOP_ADDR + ($urandom % 32'h1000);
      end
      addr[1:0] = 2'b00;
      fetch_and_compare(addr, cycles);
    end
    repeat (2) @(posedge clock); // a stray ready would show up here
    check_equal("itim_out.mem_ready count", ready_start + random_runs, ready_count);
    report_test("random");

    $display("%0d tests run, %0d ok, %0d errors", tests_run, tests_ok, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_imem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_imem_model
  import itim_pkg::*;
#(
  parameter logic [31:0] data_key = 32'h5a5a_a5a5,
  parameter int          max_wait = 4
) (
  input  logic        clock,
  input  logic        reset,
  input  mem_in_type  imem_in,
  output mem_out_type imem_out,
  output int          fetch_count
);

  int          wait_left;      // cycles still to go before the current word is served
  logic [31:0] addr_log [64];  // served addresses in order, wraps

  always_ff @(posedge clock) begin
    imem_out.mem_ready <= 1'b0;
    if (reset) begin
      imem_out.mem_rdata <= '0;
      wait_left <= int'($urandom % max_wait);
      fetch_count <= 0;
    end else if (imem_out.mem_ready) begin
      // controller steps to the next word on this edge
    end else if (imem_in.mem_valid) begin
      if (wait_left == 0) begin
        imem_out.mem_ready <= 1'b1;
        imem_out.mem_rdata <= imem_in.mem_addr ^ data_key;
        addr_log[fetch_count[5:0]] <= imem_in.mem_addr;
        fetch_count <= fetch_count + 1;
        wait_left <= int'($urandom % max_wait); // latency of the next word, 1 to max_wait
      end else begin
        wait_left <= wait_left - 1;
      end
    end
  end

endmodule

`default_nettype wire

//--- itim.sv
`timescale 1ns/1ps
`default_nettype none
`include "itim_defs.svh"

module itim
  import itim_pkg::*;
#(
  parameter int itim_enable = 1
) (
  input  logic        clock,
  input  logic        reset,
  input  mem_in_type  itim_in,
  output mem_out_type itim_out,
  input  mem_out_type imem_out,
  output mem_in_type  imem_in
);

  generate
    if (itim_enable != 0) begin : g_cached

      itim_ctrl_in_type  ictrl_in;
      itim_ctrl_out_type ictrl_out;

      itim_ctrl ctrl (
        .clock     (clock),
        .reset     (reset),
        .ictrl_in  (ictrl_in),
        .ictrl_out (ictrl_out),
        .itim_in   (itim_in),
        .itim_out  (itim_out),
        .imem_out  (imem_out),
        .imem_in   (imem_in)
      );

      itim_array #(
        .data_width (`ITIM_TAG_WIDTH)
      ) tag_array (
        .clock (clock),
        .wen   (ictrl_out.tag_in.wen),
        .waddr (ictrl_out.tag_in.waddr),
        .raddr (ictrl_out.tag_in.raddr),
        .wdata (ictrl_out.tag_in.wdata),
        .rdata (ictrl_in.tag_out.rdata)
      );

      itim_array #(
        .data_width ((2**`ITIM_WIDTH)*32) // whole line
      ) data_array (
        .clock (clock),
        .wen   (ictrl_out.data_in.wen),
        .waddr (ictrl_out.data_in.waddr),
        .raddr (ictrl_out.data_in.raddr),
        .wdata (ictrl_out.data_in.wdata),
        .rdata (ictrl_in.data_out.rdata)
      );

      itim_array #(
        .data_width (1)
      ) lock_array (
        .clock (clock),
        .wen   (ictrl_out.lock_in.wen),
        .waddr (ictrl_out.lock_in.waddr),
        .raddr (ictrl_out.lock_in.raddr),
        .wdata (ictrl_out.lock_in.wdata),
        .rdata (ictrl_in.lock_out.rdata)
      );

    end else begin : g_bypass

      // no store, fetch port goes straight to backing memory
      assign imem_in  = itim_in;
      assign itim_out = imem_out;

    end
  endgenerate

endmodule

`default_nettype wire

//--- itim_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "itim_defs.svh"

module itim_ctrl
  import itim_pkg::*;
(
  input  logic              clock,
  input  logic              reset,
  input  itim_ctrl_in_type  ictrl_in,
  output itim_ctrl_out_type ictrl_out,
  input  mem_in_type        itim_in,
  output mem_out_type       itim_out,
  input  mem_out_type       imem_out,
  output mem_in_type        imem_in
);

  localparam int depth      = `ITIM_DEPTH;
  localparam int width      = `ITIM_WIDTH;
  localparam int tag_width  = `ITIM_TAG_WIDTH;
  localparam int line_words = 2**width;
  localparam int line_bits  = line_words*32;

  localparam logic [depth-1:0] last_did = '1;
  localparam logic [width-1:0] last_cnt = '1;

  localparam logic [31:0] win_base = `ITIM_BASE_ADDR;
  localparam logic [31:0] win_size = `ITIM_TOP_ADDR - `ITIM_BASE_ADDR;

  typedef struct packed {
    logic [tag_width-1:0] tag;
    logic [depth-1:0]     did;   // line index
    logic [width-1:0]     wid;   // word within line
    logic [31:0]          addr;
    logic                 fence;
    logic                 en;
  } front_type;

  typedef struct packed {
    itim_state_type       state;
    logic [tag_width-1:0] tag;
    logic [line_bits-1:0] data;  // line being filled
    logic [depth-1:0]     did;
    logic [width-1:0]     wid;
    logic [width-1:0]     cnt;   // fill word counter
    logic [31:0]          addr;  // backing memory address
    logic                 fence;
    logic                 valid; // backing memory request level
  } back_type;

  front_type   r_f;
  front_type   rin_f;
  back_type    r_b;
  back_type    rin_b;

  logic        in_window;
  logic        fill_wen;
  logic        fence_wen;
  logic        ready;
  logic [31:0] rdata;

  // front stage: capture the request and split the address
  always_comb begin
    rin_f = r_f;
    rin_f.fence = 1'b0;
    rin_f.en = 1'b0;
    if (itim_in.mem_valid) begin
      if (itim_in.mem_fence) begin
        rin_f.fence = 1'b1;
      end else begin
        rin_f.en = 1'b1;
        rin_f.addr = itim_in.mem_addr;
        rin_f.tag = itim_in.mem_addr[31:depth+width+2];
        rin_f.did = itim_in.mem_addr[depth+width+1:width+2];
        rin_f.wid = itim_in.mem_addr[width+1:2];
      end
    end
  end

  // one unsigned compare covers both window bounds
  assign in_window = (r_f.addr - win_base) < win_size;

  // back stage
  always_comb begin
    rin_b = r_b;
    ready = 1'b0;
    rdata = '0;

    case (r_b.state)
      st_hit: begin
        rin_b.tag = r_f.tag;
        rin_b.did = r_f.did;
        rin_b.wid = r_f.wid;
        rin_b.addr = r_f.addr;
        rin_b.fence = r_f.fence;
        rin_b.valid = 1'b0;
        if (r_f.fence) begin
          rin_b.did = '0; // sweep starts at line 0
          rin_b.state = st_fence;
        end else if (r_f.en) begin
          if (!in_window) begin
            rin_b.state = st_load;
            rin_b.valid = 1'b1;
          end else if (!ictrl_in.lock_out.rdata) begin
            rin_b.state = st_miss;
            rin_b.addr[width+1:0] = '0; // line base
            rin_b.cnt = '0;
            rin_b.valid = 1'b1;
          end else if (ictrl_in.tag_out.rdata != r_f.tag) begin
            // line held by another tag, go around it
            rin_b.state = st_load;
            rin_b.valid = 1'b1;
          end else begin
            ready = 1'b1;
            rdata = ictrl_in.data_out.rdata[32*r_f.wid +: 32];
          end
        end
      end

      st_miss: begin
        if (imem_out.mem_ready) begin
          rin_b.data[32*r_b.cnt +: 32] = imem_out.mem_rdata;
          if (r_b.cnt == last_cnt) begin
            rin_b.valid = 1'b0;
            rin_b.state = st_update;
          end else begin
            rin_b.addr = r_b.addr + 32'd4;
            rin_b.cnt = r_b.cnt + 1'b1;
          end
        end
      end

      st_load: begin
        if (imem_out.mem_ready) begin
          ready = 1'b1;
          rdata = imem_out.mem_rdata;
          rin_b.valid = 1'b0;
          rin_b.state = st_hit;
        end
      end

      st_update: begin
        ready = 1'b1;
        if (!r_b.fence) begin
          rdata = r_b.data[32*r_b.wid +: 32];
        end
        rin_b.state = st_hit;
      end

      st_fence: begin
        if (r_b.did == last_did) begin
          rin_b.state = st_update;
        end else begin
          rin_b.did = r_b.did + 1'b1;
        end
      end

      default: begin
        rin_b.valid = 1'b0;
        rin_b.state = st_hit;
      end
    endcase
  end

  assign fill_wen  = (r_b.state == st_update) && !r_b.fence;
  assign fence_wen = (r_b.state == st_fence);

  always_comb begin
    // reads follow the next front register so data lines up with the back stage
    ictrl_out.tag_in.raddr  = rin_f.did;
    ictrl_out.data_in.raddr = rin_f.did;
    ictrl_out.lock_in.raddr = rin_f.did;

    ictrl_out.tag_in.wen   = fill_wen;
    ictrl_out.tag_in.waddr = r_b.did;
    ictrl_out.tag_in.wdata = r_b.tag;

    ictrl_out.data_in.wen   = fill_wen;
    ictrl_out.data_in.waddr = r_b.did;
    ictrl_out.data_in.wdata = r_b.data;

    ictrl_out.lock_in.wen   = fill_wen | fence_wen;
    ictrl_out.lock_in.waddr = r_b.did;
    ictrl_out.lock_in.wdata = fill_wen; // set on fill, cleared by fence
  end

  always_comb begin
    // in st_hit the request goes out at once, later it holds until ready
    if (r_b.state == st_hit) begin
      imem_in.mem_valid = rin_b.valid;
      imem_in.mem_addr  = rin_b.addr;
    end else begin
      imem_in.mem_valid = r_b.valid;
      imem_in.mem_addr  = r_b.addr;
    end
    imem_in.mem_fence = 1'b0;
    imem_in.mem_instr = 1'b1;
    imem_in.mem_wdata = '0;
    imem_in.mem_wstrb = '0;

    itim_out.mem_ready = ready;
    itim_out.mem_rdata = rdata;
  end

  always_ff @(posedge clock) begin
    r_f <= rin_f;
    r_b <= rin_b;
    if (reset) begin
      r_f.en <= 1'b0;
      r_f.fence <= 1'b0;
      r_b.state <= st_hit;
      r_b.valid <= 1'b0;
      r_b.fence <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- itim_array.sv
`timescale 1ns/1ps
`default_nettype none
`include "itim_defs.svh"

module itim_array #(
  parameter int data_width = 32
) (
  input  logic                   clock,
  input  logic                   wen,
  input  logic [`ITIM_DEPTH-1:0] waddr,
  input  logic [`ITIM_DEPTH-1:0] raddr,
  input  logic [data_width-1:0]  wdata,
  output logic [data_width-1:0]  rdata
);

  logic [data_width-1:0]  mem [2**`ITIM_DEPTH] = '{default: '0};
  logic [`ITIM_DEPTH-1:0] raddr_q = '0;

  // registered read address, data follows one cycle later
  always_ff @(posedge clock) begin
    raddr_q <= raddr;
    if (wen) begin
      mem[waddr] <= wdata;
    end
  end

  assign rdata = mem[raddr_q];

endmodule

`default_nettype wire

//--- itim_pkg.sv
`default_nettype none
`include "itim_defs.svh"

package itim_pkg;

  typedef struct packed {
    logic        mem_valid;
    logic        mem_fence;
    logic        mem_instr;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [3:0]  mem_wstrb;
  } mem_in_type;

  typedef struct packed {
    logic        mem_ready;
    logic [31:0] mem_rdata;
  } mem_out_type;

  typedef struct packed {
    logic                       wen;
    logic [`ITIM_DEPTH-1:0]     waddr;
    logic [`ITIM_DEPTH-1:0]     raddr;
    logic [`ITIM_TAG_WIDTH-1:0] wdata;
  } itim_tag_in_type;

  typedef struct packed {
    logic [`ITIM_TAG_WIDTH-1:0] rdata;
  } itim_tag_out_type;

  // one whole line per entry
  typedef struct packed {
    logic                                wen;
    logic [`ITIM_DEPTH-1:0]              waddr;
    logic [`ITIM_DEPTH-1:0]              raddr;
    logic [(2**`ITIM_WIDTH)*32-1:0]      wdata;
  } itim_data_in_type;

  typedef struct packed {
    logic [(2**`ITIM_WIDTH)*32-1:0] rdata;
  } itim_data_out_type;

  typedef struct packed {
    logic                   wen;
    logic [`ITIM_DEPTH-1:0] waddr;
    logic [`ITIM_DEPTH-1:0] raddr;
    logic                   wdata;
  } itim_lock_in_type;

  typedef struct packed {
    logic rdata;
  } itim_lock_out_type;

  typedef struct packed {
    itim_tag_out_type  tag_out;
    itim_data_out_type data_out;
    itim_lock_out_type lock_out;
  } itim_ctrl_in_type;

  typedef struct packed {
    itim_tag_in_type  tag_in;
    itim_data_in_type data_in;
    itim_lock_in_type lock_in;
  } itim_ctrl_out_type;

  typedef enum logic [2:0] {
    st_hit,
    st_miss,
    st_load,
    st_update,
    st_fence
  } itim_state_type;

endpackage

`default_nettype wire

//--- itim_defs.svh
`ifndef ITIM_DEFS_SVH
`define ITIM_DEFS_SVH

// line store geometry, both given as log2
`define ITIM_DEPTH 4
`define ITIM_WIDTH 2

// word address bits left over once index and word offset are taken
`define ITIM_TAG_WIDTH (30 - `ITIM_DEPTH - `ITIM_WIDTH)

// cached window, top is exclusive
`define ITIM_BASE_ADDR 32'h0000_0000
`define ITIM_TOP_ADDR 32'h0001_0000

`endif
